// File: mango_mem.f
rtl/mem_pkg.sv
rtl/mem_control.sv
rtl/store_align.sv
rtl/data_ram.sv
rtl/load_align.sv
rtl/mem_stage_top.sv
test/mem_checker.sv
test/tb_mem_stage.sv

// File: Makefile
# Verilator build and run of the memory stage testbench

.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing -j 0 --top-module tb_mem_stage -f mango_mem.f --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log
	cat sim.log

check: run
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_mem_stage.sv
////////////////////////////////////////////////////////////
// memory stage testbench
// directed and random requests against a reference model
////////////////////////////////////////////////////////////
`default_nettype none

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          total_reqs = 8 + 22 + 17 + 36 + 10 + 400;
    localparam logic [31:0] base       = 32'h0000_0400;

    logic              clk;
    logic              rst;
    mem_pkg::mem_req_t req;
    mem_pkg::wb_t      wb;
    mem_pkg::wb_t      exp_in;
    int                errors;
    int                checks;
    int                pending;
    int                tests;
    int                test_start;
    // eight word window starting at base
    logic [31:0]       model [0:7];

    mem_stage_top #(.addr_bits(10)) UUT (.clk(clk), .rst(rst), .req(req), .wb(wb));

    mem_checker u_checker (.clk(clk), .rst(rst), .exp_in(exp_in), .wb(wb),
                           .errors(errors), .checks(checks), .pending(pending));

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // expected writeback record for one request against the current memory word
    function automatic mem_pkg::wb_t expect_wb(input mem_pkg::mem_op_t op,
                                               input logic [4:0] dest, input logic [31:0] addr,
                                               input logic [31:0] opr2, input logic [31:0] alures,
                                               input logic [31:0] word);
        mem_pkg::wb_t r;
        int           off;
        int           hsel;
        logic [7:0]   b;
        logic [15:0]  h;
        off  = int'(addr[1:0]);
        hsel = addr[1] ? 16 : 0;
        b    = word[8*off +: 8];
        h    = word[hsel +: 16];
        r.valid    = 1'b1;
        r.dest     = dest;
        r.data     = alures;
        r.addr_err = 1'b0;
        case (op)
            mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: r.addr_err = addr[0];
            mem_pkg::op_lw, mem_pkg::op_sw: r.addr_err = (off != 0);
            default: begin
            end
        endcase
        case (op)
            mem_pkg::op_lb:  r.data = {{24{b[7]}}, b};
            mem_pkg::op_lbu: r.data = {24'b0, b};
            mem_pkg::op_lh:  r.data = addr[0] ? 32'b0 : {{16{h[15]}}, h};
            mem_pkg::op_lhu: r.data = addr[0] ? 32'b0 : {16'b0, h};
            mem_pkg::op_lw:  r.data = word;
            mem_pkg::op_lwl: begin
                r.data = opr2;
                for (int i = 0; i <= off; i++) r.data[8*(3-off+i) +: 8] = word[8*i +: 8];
            end
            mem_pkg::op_lwr: begin
                r.data = opr2;
                for (int i = off; i < 4; i++) r.data[8*(i-off) +: 8] = word[8*i +: 8];
            end
            default: begin
            end
        endcase
        return r;
    endfunction

    // memory word after a store, unchanged when the store is misaligned
    function automatic logic [31:0] store_word(input mem_pkg::mem_op_t op,
                                               input logic [31:0] addr, input logic [31:0] opr2,
                                               input logic [31:0] word);
        logic [31:0] w;
        int          off;
        w   = word;
        off = int'(addr[1:0]);
        case (op)
            mem_pkg::op_sb: w[8*off +: 8] = opr2[7:0];
            mem_pkg::op_sh: if (!addr[0]) w[(addr[1] ? 16 : 0) +: 16] = opr2[15:0];
            mem_pkg::op_sw: if (off == 0) w = opr2;
            mem_pkg::op_swl: for (int i = 0; i <= off; i++) w[8*i +: 8] = opr2[8*(3-off+i) +: 8];
            mem_pkg::op_swr: for (int i = off; i < 4; i++) w[8*i +: 8] = opr2[8*(i-off) +: 8];
            default: begin
            end
        endcase
        return w;
    endfunction

    // called at a falling edge, drives one request and returns at the next one
    task automatic send(input mem_pkg::mem_op_t op, input logic [31:0] addr,
                        input logic [31:0] opr2);
        int w;
        w          = int'(addr[4:2]);
        req.valid  = 1'b1;
        req.op     = op;
        req.dest   = 5'($urandom);
        req.addr   = addr;
        req.opr2   = opr2;
        req.alures = $urandom;
        exp_in     = expect_wb(op, req.dest, addr, opr2, req.alures, model[w]);
        model[w]   = store_word(op, addr, opr2, model[w]);
        @(negedge clk);
        req.valid    = 1'b0;
        exp_in.valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        while (pending != 0) @(negedge clk);
        tests++;
        if (errors == test_start) $display("test %0s: ok", name);
        else $display("test %0s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        logic [31:0]      a;
        logic [31:0]      r1;
        logic [31:0]      junk;
        logic [31:0]      last_a;
        logic             last_st;
        mem_pkg::mem_op_t op;
        mem_pkg::wb_t     rec;
        void'($urandom(32'h3f18_dd62));
        req        = '0;
        exp_in     = '0;
        rst        = 1'b1;
        tests      = 0;
        test_start = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 8; i++) send(mem_pkg::op_alu, base + $urandom_range(0, 31), $urandom);
        end_test("alu passthrough");

        for (int w = 0; w < 8; w++) send(mem_pkg::op_sw, base + 4 * w, $urandom);
        for (int off = 0; off < 4; off++) begin
            send(mem_pkg::op_sb, base + off, $urandom);
            send(mem_pkg::op_lw, base, $urandom);
        end
        for (int off = 0; off < 4; off += 2) begin
            send(mem_pkg::op_sh, base + 4 + off, $urandom);
            send(mem_pkg::op_lw, base + 4, $urandom);
        end
        send(mem_pkg::op_sw, base + 8, $urandom);
        send(mem_pkg::op_lw, base + 8, $urandom);
        end_test("aligned stores and loads");

        // bytes and halfwords of both signs
        send(mem_pkg::op_sw, base + 12, 32'h8f70_63f1);
        for (int off = 0; off < 4; off++) begin
            send(mem_pkg::op_lb, base + 12 + off, $urandom);
            send(mem_pkg::op_lbu, base + 12 + off, $urandom);
            send(mem_pkg::op_lh, base + 12 + off, $urandom);
            send(mem_pkg::op_lhu, base + 12 + off, $urandom);
        end
        end_test("byte and halfword extension");

        for (int off = 0; off < 4; off++) begin
            send(mem_pkg::op_lwl, base + 16 + off, $urandom);
            send(mem_pkg::op_lwr, base + 16 + off, $urandom);
            send(mem_pkg::op_swl, base + 20 + off, $urandom);
            send(mem_pkg::op_lw, base + 20, $urandom);
            send(mem_pkg::op_swr, base + 24 + off, $urandom);
            send(mem_pkg::op_lw, base + 24, $urandom);
        end
        // an unaligned word across words 6 and 7, written and read back as pairs
        for (int off = 1; off < 4; off++) begin
            a    = base + 24 + off;
            junk = $urandom;
            r1   = $urandom;
            send(mem_pkg::op_swr, a, r1);
            send(mem_pkg::op_swl, a + 3, r1);
            rec = expect_wb(mem_pkg::op_lwr, 5'd0, a, junk, 32'd0, model[6]);
            r1  = rec.data;
            send(mem_pkg::op_lwr, a, junk);
            send(mem_pkg::op_lwl, a + 3, r1);
        end
        end_test("unaligned pairs");

        for (int off = 1; off < 4; off += 2) begin
            send(mem_pkg::op_sh, base + 8 + off, $urandom);
            send(mem_pkg::op_lw, base + 8, $urandom);
        end
        for (int off = 1; off < 4; off++) begin
            send(mem_pkg::op_sw, base + 8 + off, $urandom);
            send(mem_pkg::op_lw, base + 8, $urandom);
        end
        end_test("misaligned stores");

        last_st = 1'b0;
        last_a  = base;
        for (int i = 0; i < 400; i++) begin
            op = mem_pkg::mem_op_t'(4'($urandom_range(0, 12)));
            a  = base + $urandom_range(0, 31);
            // often reload the word that the previous store just wrote
            if (last_st && $urandom_range(0, 1) == 1) begin
                op = mem_pkg::op_lw;
                a  = {last_a[31:2], 2'b00};
            end
            last_st = (op >= mem_pkg::op_sb);
            last_a  = a;
            send(op, a, $urandom);
        end
        end_test("random stream");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // limit counted from the end of reset
    initial begin
        @(negedge rst);
        #((total_reqs + 20) * 100);
        $display("timeout: the writeback stream did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/mem_checker.sv
////////////////////////////////////////////////////////////
// writeback checker
// compares each wb record with the expected one two edges on
////////////////////////////////////////////////////////////
`default_nettype none

module mem_checker (
    input  wire               clk,
    input  wire               rst,
    input  wire mem_pkg::wb_t exp_in,
    input  wire mem_pkg::wb_t wb,
    output int                errors,
    output int                checks,
    output int                pending
);
    timeunit 1ns;
    timeprecision 1ps;

    mem_pkg::wb_t want_q[$];
    int           edge_q[$];
    int           edge_no;
    mem_pkg::wb_t want;

    always @(posedge clk) begin
        if (rst) begin
            errors  = 0;
            checks  = 0;
            edge_no = 0;
            want_q.delete();
            edge_q.delete();
        end else begin
            edge_no = edge_no + 1;
            // a record whose slot has passed was never written back
            while (edge_q.size() > 0 && edge_q[0] + 2 < edge_no) begin
                $display("ERROR: writeback for dest %0d was never seen", want_q[0].dest);
                errors++;
                void'(want_q.pop_front());
                void'(edge_q.pop_front());
            end
            if (wb.valid) begin
                if (edge_q.size() == 0 || edge_q[0] + 2 != edge_no) begin
                    $display("ERROR: writeback for dest %0d came with no request two edges earlier",
                             wb.dest);
                    errors++;
                end else begin
                    want = want_q.pop_front();
                    void'(edge_q.pop_front());
                    checks++;
                    if (wb.data !== want.data) begin
                        $display("FAIL wb.data: got %h expected %h", wb.data, want.data);
                        errors++;
                    end
                    if (wb.dest !== want.dest) begin
                        $display("FAIL wb.dest: got %h expected %h", wb.dest, want.dest);
                        errors++;
                    end
                    if (wb.addr_err !== want.addr_err) begin
                        $display("FAIL wb.addr_err: got %h expected %h", wb.addr_err,
                                 want.addr_err);
                        errors++;
                    end
                end
            end
            if (exp_in.valid) begin
                want_q.push_back(exp_in);
                edge_q.push_back(edge_no);
            end
        end
        pending = want_q.size();
    end

endmodule

`default_nettype wire

// File: rtl/mem_stage_top.sv
////////////////////////////////////////////////////////////
// memory and writeback stage
// ties control, store path, data RAM and load path together
////////////////////////////////////////////////////////////
`default_nettype none

module mem_stage_top #(
    parameter int addr_bits = 10
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire mem_pkg::mem_req_t req,
    output mem_pkg::wb_t           wb
);

    logic                 store_en;
    logic [addr_bits-1:0] ram_addr;
    logic [3:0]           byte_en;
    logic [31:0]          wdata;
    logic [31:0]          rdata;
    logic [31:0]          load_word;
    mem_pkg::mem_stage_t  stage;

    mem_control #(
        .addr_bits (addr_bits)
    ) u_control (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .load_word (load_word),
        .store_en  (store_en),
        .ram_addr  (ram_addr),
        .stage     (stage),
        .wb        (wb)
    );

    // the store path works on the incoming request in the same cycle
    store_align u_store (
        .op       (req.op),
        .offset   (req.addr[1:0]),
        .opr2     (req.opr2),
        .store_en (store_en),
        .byte_en  (byte_en),
        .wdata    (wdata)
    );

    data_ram #(
        .addr_bits (addr_bits)
    ) u_ram (
        .clk     (clk),
        .addr    (ram_addr),
        .byte_en (byte_en),
        .wdata   (wdata),
        .rdata   (rdata)
    );

    load_align u_load (
        .stage     (stage),
        .rdata     (rdata),
        .load_word (load_word)
    );

endmodule

`default_nettype wire

// File: rtl/load_align.sv
////////////////////////////////////////////////////////////
// load alignment and writeback select
// field pick, extension, LWL/LWR merge and ALU result mux
////////////////////////////////////////////////////////////
`default_nettype none

module load_align (
    input  wire mem_pkg::mem_stage_t stage,
    input  wire [31:0]               rdata,
    output logic [31:0]              load_word
);

    logic [31:0] memdata;
    logic        memtoreg;

    always_comb begin
        memtoreg = 1'b1;
        memdata  = 32'b0;
        case (stage.op)
            mem_pkg::op_lb: begin
                case (stage.offset)
                    2'b00: memdata = {{24{rdata[7]}}, rdata[7:0]};
                    2'b01: memdata = {{24{rdata[15]}}, rdata[15:8]};
                    2'b10: memdata = {{24{rdata[23]}}, rdata[23:16]};
                    default: memdata = {{24{rdata[31]}}, rdata[31:24]};
                endcase
            end

            mem_pkg::op_lbu: begin
                case (stage.offset)
                    2'b00: memdata = {24'b0, rdata[7:0]};
                    2'b01: memdata = {24'b0, rdata[15:8]};
                    2'b10: memdata = {24'b0, rdata[23:16]};
                    default: memdata = {24'b0, rdata[31:24]};
                endcase
            end

            // odd halfword offsets fall through to zero
            mem_pkg::op_lh: begin
                case (stage.offset)
                    2'b00: memdata = {{16{rdata[15]}}, rdata[15:0]};
                    2'b10: memdata = {{16{rdata[31]}}, rdata[31:16]};
                    default: memdata = 32'b0;
                endcase
            end

            mem_pkg::op_lhu: begin
                case (stage.offset)
                    2'b00: memdata = {16'b0, rdata[15:0]};
                    2'b10: memdata = {16'b0, rdata[31:16]};
                    default: memdata = 32'b0;
                endcase
            end

            mem_pkg::op_lw: begin
                memdata = rdata;
            end

            mem_pkg::op_lwl: begin
                case (stage.offset)
                    2'b00: memdata = {rdata[7:0], stage.opr2[23:0]};
                    2'b01: memdata = {rdata[15:0], stage.opr2[15:0]};
                    2'b10: memdata = {rdata[23:0], stage.opr2[7:0]};
                    default: memdata = rdata;
                endcase
            end

            mem_pkg::op_lwr: begin
                case (stage.offset)
                    2'b00: memdata = rdata;
                    2'b01: memdata = {stage.opr2[31:24], rdata[31:8]};
                    2'b10: memdata = {stage.opr2[31:16], rdata[31:16]};
                    default: memdata = {stage.opr2[31:8], rdata[31:24]};
                endcase
            end

            // ALU results and stores write back the ALU value
            default: begin
                memtoreg = 1'b0;
            end
        endcase
    end

    assign load_word = memtoreg ? memdata : stage.alures;

endmodule

`default_nettype wire

// File: rtl/data_ram.sv
////////////////////////////////////////////////////////////
// data RAM
// word wide, byte write enables, write-before-read per lane
////////////////////////////////////////////////////////////
`default_nettype none

module data_ram #(
    parameter int addr_bits = 10
) (
    input  wire                 clk,
    input  wire [addr_bits-1:0] addr,
    input  wire [3:0]           byte_en,
    input  wire [31:0]          wdata,
    output logic [31:0]         rdata
);

    localparam int depth = 1 << addr_bits;

    // each word is kept as four byte lanes
    logic [3:0][7:0] mem [0:depth-1];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                mem[addr][i]    <= wdata[8*i +: 8];
                // a written lane reads back the new byte
                rdata[8*i +: 8] <= wdata[8*i +: 8];
            end else begin
                rdata[8*i +: 8] <= mem[addr][i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/store_align.sv
////////////////////////////////////////////////////////////
// store lane steering
// byte enables and shifted write data for every store type
////////////////////////////////////////////////////////////
`default_nettype none

module store_align (
    input  wire mem_pkg::mem_op_t op,
    input  wire [1:0]             offset,
    input  wire [31:0]            opr2,
    input  wire                   store_en,
    output logic [3:0]            byte_en,
    output logic [31:0]           wdata
);

    logic [3:0] lane_en;

    always_comb begin
        lane_en = 4'b0000;
        wdata   = opr2;
        case (op)
            mem_pkg::op_sb: begin
                lane_en = 4'b0001 << offset;
                wdata   = {4{opr2[7:0]}};
            end

            mem_pkg::op_sh: begin
                lane_en = offset[1] ? 4'b1100 : 4'b0011;
                wdata   = {2{opr2[15:0]}};
            end

            mem_pkg::op_sw: begin
                lane_en = 4'b1111;
                wdata   = opr2;
            end

            // high bytes of the register go to lanes offset down to 0
            mem_pkg::op_swl: begin
                case (offset)
                    2'b00: begin
                        lane_en = 4'b0001;
                        wdata   = {24'b0, opr2[31:24]};
                    end
                    2'b01: begin
                        lane_en = 4'b0011;
                        wdata   = {16'b0, opr2[31:16]};
                    end
                    2'b10: begin
                        lane_en = 4'b0111;
                        wdata   = {8'b0, opr2[31:8]};
                    end
                    default: begin
                        lane_en = 4'b1111;
                        wdata   = opr2;
                    end
                endcase
            end

            // low bytes of the register go to lanes 3 down to offset
            mem_pkg::op_swr: begin
                case (offset)
                    2'b00: begin
                        lane_en = 4'b1111;
                        wdata   = opr2;
                    end
                    2'b01: begin
                        lane_en = 4'b1110;
                        wdata   = {opr2[23:0], 8'b0};
                    end
                    2'b10: begin
                        lane_en = 4'b1100;
                        wdata   = {opr2[15:0], 16'b0};
                    end
                    default: begin
                        lane_en = 4'b1000;
                        wdata   = {opr2[7:0], 24'b0};
                    end
                endcase
            end

            default: begin
            end
        endcase
    end

    assign byte_en = store_en ? lane_en : 4'b0000;

endmodule

`default_nettype wire

// File: rtl/mem_control.sv
////////////////////////////////////////////////////////////
// memory stage control
// size decode, alignment check, store gating and pipe registers
////////////////////////////////////////////////////////////
`default_nettype none

module mem_control #(
    parameter int addr_bits = 10
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire mem_pkg::mem_req_t req,
    input  wire [31:0]             load_word,
    output logic                   store_en,
    output logic [addr_bits-1:0]   ram_addr,
    output mem_pkg::mem_stage_t    stage,
    output mem_pkg::wb_t           wb
);

    logic                is_half;
    logic                is_word;
    logic                is_store;
    logic                addr_err;
    mem_pkg::mem_stage_t stage_next;
    mem_pkg::wb_t        wb_next;

    ////////////////////////////////////////////////////////////
    // access size decode
    ////////////////////////////////////////////////////////////

    // byte, LWL/LWR and SWL/SWR accesses never fault on alignment
    always_comb begin
        is_half  = 1'b0;
        is_word  = 1'b0;
        is_store = 1'b0;
        case (req.op)
            mem_pkg::op_lh, mem_pkg::op_lhu: begin
                is_half = 1'b1;
            end
            mem_pkg::op_sh: begin
                is_half  = 1'b1;
                is_store = 1'b1;
            end
            mem_pkg::op_lw: begin
                is_word = 1'b1;
            end
            mem_pkg::op_sw: begin
                is_word  = 1'b1;
                is_store = 1'b1;
            end
            mem_pkg::op_sb, mem_pkg::op_swl, mem_pkg::op_swr: begin
                is_store = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign addr_err = (is_half & req.addr[0]) | (is_word & (|req.addr[1:0]));

    // a faulting store must leave the RAM untouched
    assign store_en = req.valid & is_store & ~addr_err;
    assign ram_addr = req.addr[addr_bits+1:2];

    ////////////////////////////////////////////////////////////
    // pipeline registers
    ////////////////////////////////////////////////////////////

    always_comb begin
        stage_next.valid    = req.valid;
        stage_next.op       = req.op;
        stage_next.dest     = req.dest;
        stage_next.offset   = req.addr[1:0];
        stage_next.opr2     = req.opr2;
        stage_next.alures   = req.alures;
        stage_next.addr_err = addr_err;

        wb_next.valid    = stage.valid;
        wb_next.dest     = stage.dest;
        wb_next.data     = load_word;
        wb_next.addr_err = stage.addr_err;
    end

    always_ff @(posedge clk) begin
        stage <= stage_next;
        wb    <= wb_next;
        if (rst) begin
            stage.valid <= 1'b0;
            wb.valid    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
////////////////////////////////////////////////////////////
// memory stage definitions
// operation codes and the records passed along the pipe
////////////////////////////////////////////////////////////
`default_nettype none

package mem_pkg;

    // memory operation carried with each instruction from execute
    typedef enum logic [3:0] {
        op_alu,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwl,
        op_lwr,
        op_sb,
        op_sh,
        op_sw,
        op_swl,
        op_swr
    } mem_op_t;

    // one instruction arriving from the execute stage
    typedef struct packed {
        logic        valid;
        mem_op_t     op;
        logic [4:0]  dest;
        logic [31:0] addr;
        logic [31:0] opr2;
        logic [31:0] alures;
    } mem_req_t;

    // record held in the memory-stage register while the RAM read is in flight
    typedef struct packed {
        logic        valid;
        mem_op_t     op;
        logic [4:0]  dest;
        logic [1:0]  offset;
        logic [31:0] opr2;
        logic [31:0] alures;
        logic        addr_err;
    } mem_stage_t;

    // result handed to the register file
    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;
        logic [31:0] data;
        logic        addr_err;
    } wb_t;

endpackage

`default_nettype wire
